//--- simd_unit_params.svh
// SIMD unit parameters
`ifndef SIMD_UNIT_PARAMS_SVH
`define SIMD_UNIT_PARAMS_SVH

// width of one packed lane
`define SIMD_LANE_W 32

// lanes per operand word
`define SIMD_LANES 2

// result forwarding buses
`define SIMD_NFWD 4

// retire cause for integer overflow
`define SIMD_RET_OVF 4'd5

// derived widths
`define SIMD_WORD_W (`SIMD_LANES * `SIMD_LANE_W)
`define SIMD_FLAG_W (2 * `SIMD_LANES)
`define SIMD_SEL_W 4
`define SIMD_RET_W 8

`endif

//--- simd_unit_pkg.sv
// SIMD unit types
`include "simd_unit_params.svh"

package simd_unit_pkg;

  typedef logic [`SIMD_LANE_W-1:0] lane_t;

  // lane 0 in the low half
  typedef logic [`SIMD_WORD_W-1:0] word_t;

  // 0 register, 1..4 live bus, 5..8 bus one edge back
  typedef logic [`SIMD_SEL_W-1:0] fwd_sel_t;

  typedef logic [`SIMD_LANES-1:0] lane_mask_t;

  // per lane {less, equal}, lane 0 low
  typedef logic [`SIMD_FLAG_W-1:0] flags_t;

  // {cause, 2'b00, lane mask}
  typedef logic [`SIMD_RET_W-1:0] ret_code_t;

  typedef enum logic [3:0] {
    OP_ADD   = 4'd0,
    OP_SUB   = 4'd1,
    OP_RSUB  = 4'd2,
    OP_AND   = 4'd4,
    OP_OR    = 4'd5,
    OP_XOR   = 4'd6,
    OP_ANDN  = 4'd7,
    OP_SWAP  = 4'd8,
    OP_DUPLO = 4'd9,
    OP_CMPEQ = 4'd10,
    OP_CMPLT = 4'd11
  } op_t;

endpackage

//--- exec_ctrl_if.sv
// decoded lane controls
interface exec_ctrl_if;
  logic       valid;
  logic       arith;
  logic       sub;
  logic       rsub;
  logic       logic_en;
  // low opcode bits, also selects lt for compares
  logic [1:0] logic_sel;
  logic       perm_swap;
  logic       perm_dup;
  logic       cmp;
  // 0 alu, 1 compare/permute
  logic       unit_sel;

  modport decoder (
    output valid, arith, sub, rsub, logic_en, logic_sel,
           perm_swap, perm_dup, cmp, unit_sel
  );

  modport lanes (
    input valid, arith, sub, rsub, logic_en, logic_sel,
          perm_swap, perm_dup, cmp, unit_sel
  );

endinterface

//--- operand_select.sv
// operand forwarding select
`include "simd_unit_params.svh"

module operand_select
  import simd_unit_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  word_t    a_reg,
  input  word_t    b_reg,
  input  fwd_sel_t a_sel,
  input  fwd_sel_t b_sel,
  input  word_t    fwd_bus [`SIMD_NFWD],
  output word_t    a_op,
  output word_t    b_op
);

  // bus values from the previous edge
  word_t fwd_hist [`SIMD_NFWD];

  function automatic word_t pick(fwd_sel_t sel, word_t reg_val);
    word_t val;
    val = reg_val;
    if (sel >= 1 && sel <= `SIMD_NFWD) begin
      val = fwd_bus[sel - 1];
    end else if (sel > `SIMD_NFWD && sel <= 2 * `SIMD_NFWD) begin
      val = fwd_hist[sel - `SIMD_NFWD - 1];
    end
    return val;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      a_op <= '0;
      b_op <= '0;
      for (int i = 0; i < `SIMD_NFWD; i++) begin
        fwd_hist[i] <= '0;
      end
    end else begin
      a_op <= pick(a_sel, a_reg);
      b_op <= pick(b_sel, b_reg);
      // every bus sampled at every edge
      for (int i = 0; i < `SIMD_NFWD; i++) begin
        fwd_hist[i] <= fwd_bus[i];
      end
    end
  end

endmodule

//--- op_decode.sv
// opcode decode stage
module op_decode
  import simd_unit_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic issue_en,
  input  op_t  op,
  exec_ctrl_if.decoder ctrl
);

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl.valid     <= 1'b0;
      ctrl.arith     <= 1'b0;
      ctrl.sub       <= 1'b0;
      ctrl.rsub      <= 1'b0;
      ctrl.logic_en  <= 1'b0;
      ctrl.logic_sel <= 2'b00;
      ctrl.perm_swap <= 1'b0;
      ctrl.perm_dup  <= 1'b0;
      ctrl.cmp       <= 1'b0;
      ctrl.unit_sel  <= 1'b0;
    end else begin
      // one cycle per issued op
      ctrl.valid     <= issue_en;
      ctrl.arith     <= op inside {OP_ADD, OP_SUB, OP_RSUB};
      ctrl.sub       <= op inside {OP_SUB, OP_RSUB};
      ctrl.rsub      <= (op == OP_RSUB);
      ctrl.logic_en  <= op inside {OP_AND, OP_OR, OP_XOR, OP_ANDN};
      // position inside the group of four
      ctrl.logic_sel <= op[1:0];
      ctrl.perm_swap <= (op == OP_SWAP);
      ctrl.perm_dup  <= (op == OP_DUPLO);
      ctrl.cmp       <= op inside {OP_CMPEQ, OP_CMPLT};
      ctrl.unit_sel  <= op inside {OP_SWAP, OP_DUPLO, OP_CMPEQ, OP_CMPLT};
    end
  end

endmodule

//--- lane_alu.sv
// per-lane integer alu
`include "simd_unit_params.svh"

module lane_alu
  import simd_unit_pkg::*;
(
  input  word_t      a_op,
  input  word_t      b_op,
  exec_ctrl_if.lanes ctrl,
  output word_t      alu_res,
  output lane_mask_t ovf
);

  always_comb begin
    lane_t x;
    lane_t y;
    lane_t s;
    lane_t l;
    alu_res = '0;
    ovf = '0;
    for (int i = 0; i < `SIMD_LANES; i++) begin
      // rsub just swaps the operands
      x = ctrl.rsub ? b_op[i*`SIMD_LANE_W +: `SIMD_LANE_W] : a_op[i*`SIMD_LANE_W +: `SIMD_LANE_W];
      y = ctrl.rsub ? a_op[i*`SIMD_LANE_W +: `SIMD_LANE_W] : b_op[i*`SIMD_LANE_W +: `SIMD_LANE_W];
      s = ctrl.sub ? x - y : x + y;
      case (ctrl.logic_sel)
        2'd0:    l = x & y;
        2'd1:    l = x | y;
        2'd2:    l = x ^ y;
        default: l = x & ~y;
      endcase
      if (ctrl.arith) begin
        alu_res[i*`SIMD_LANE_W +: `SIMD_LANE_W] = s;
        // same effective signs in, different sign out
        ovf[i] = (x[`SIMD_LANE_W-1] == (y[`SIMD_LANE_W-1] ^ ctrl.sub)) &&
                 (s[`SIMD_LANE_W-1] != x[`SIMD_LANE_W-1]);
      end else if (ctrl.logic_en) begin
        alu_res[i*`SIMD_LANE_W +: `SIMD_LANE_W] = l;
      end
    end
  end

endmodule

//--- lane_cmp_perm.sv
// packed compare and permute
`include "simd_unit_params.svh"

module lane_cmp_perm
  import simd_unit_pkg::*;
(
  input  word_t      a_op,
  input  word_t      b_op,
  exec_ctrl_if.lanes ctrl,
  output word_t      cp_res,
  output flags_t     cmp_flags
);

  lane_t a_lo;
  lane_t a_hi;

  assign a_lo = a_op[`SIMD_LANE_W-1:0];
  assign a_hi = a_op[`SIMD_WORD_W-1:`SIMD_LANE_W];

  always_comb begin
    lane_t a_l;
    lane_t b_l;
    logic hit;
    cp_res = '0;
    cmp_flags = '0;
    for (int i = 0; i < `SIMD_LANES; i++) begin
      a_l = a_op[i*`SIMD_LANE_W +: `SIMD_LANE_W];
      b_l = b_op[i*`SIMD_LANE_W +: `SIMD_LANE_W];
      cmp_flags[2*i]   = (a_l == b_l);
      cmp_flags[2*i+1] = ($signed(a_l) < $signed(b_l));
      // odd position in the group is cmplt
      hit = ctrl.logic_sel[0] ? cmp_flags[2*i+1] : cmp_flags[2*i];
      if (ctrl.cmp) begin
        cp_res[i*`SIMD_LANE_W +: `SIMD_LANE_W] = {`SIMD_LANE_W{hit}};
      end
    end
    if (ctrl.perm_swap) begin
      cp_res = {a_lo, a_hi};
    end else if (ctrl.perm_dup) begin
      cp_res = {a_lo, a_lo};
    end
  end

endmodule

//--- writeback_retire.sv
// result writeback and retire
`include "simd_unit_params.svh"

module writeback_retire
  import simd_unit_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  word_t      alu_res,
  input  word_t      cp_res,
  input  lane_mask_t ovf,
  input  flags_t     cmp_flags,
  input  lane_mask_t ovf_enable,
  exec_ctrl_if.lanes ctrl,
  output word_t      result,
  output logic       result_valid,
  output flags_t     flags,
  output ret_code_t  ret_code,
  output logic       ret_en
);

  lane_mask_t ovf_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      result       <= '0;
      result_valid <= 1'b0;
      flags        <= '0;
      ovf_q        <= '0;
      ret_code     <= '0;
      ret_en       <= 1'b0;
    end else begin
      result_valid <= ctrl.valid;
      if (ctrl.valid) begin
        result <= ctrl.unit_sel ? cp_res : alu_res;
      end
      // flags hold across non-compare ops
      if (ctrl.valid && ctrl.cmp) begin
        flags <= cmp_flags;
      end
      ovf_q <= ovf & ovf_enable & {`SIMD_LANES{ctrl.valid}};
      // retire one stage behind the result
      ret_en   <= |ovf_q;
      ret_code <= (|ovf_q) ? {`SIMD_RET_OVF, 2'b00, ovf_q} : '0;
    end
  end

endmodule

//--- simd_unit.sv
// packed integer execution unit
`include "simd_unit_params.svh"

module simd_unit
  import simd_unit_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       issue_en,
  input  op_t        op,
  input  word_t      a_reg,
  input  word_t      b_reg,
  input  fwd_sel_t   a_sel,
  input  fwd_sel_t   b_sel,
  input  word_t      fwd_bus0,
  input  word_t      fwd_bus1,
  input  word_t      fwd_bus2,
  input  word_t      fwd_bus3,
  input  lane_mask_t ovf_enable,
  output word_t      result,
  output logic       result_valid,
  output flags_t     flags,
  output ret_code_t  ret_code,
  output logic       ret_en
);

  word_t      fwd_bus [`SIMD_NFWD];
  word_t      a_op;
  word_t      b_op;
  word_t      alu_res;
  word_t      cp_res;
  lane_mask_t ovf;
  flags_t     cmp_flags;

  exec_ctrl_if ctrl ();

  assign fwd_bus[0] = fwd_bus0;
  assign fwd_bus[1] = fwd_bus1;
  assign fwd_bus[2] = fwd_bus2;
  assign fwd_bus[3] = fwd_bus3;

  operand_select u_sel (
    .clk(clk), .rst(rst), .a_reg(a_reg), .b_reg(b_reg),
    .a_sel(a_sel), .b_sel(b_sel), .fwd_bus(fwd_bus), .a_op(a_op), .b_op(b_op)
  );

  op_decode u_dec (.clk(clk), .rst(rst), .issue_en(issue_en), .op(op), .ctrl(ctrl));

  lane_alu u_alu (.a_op(a_op), .b_op(b_op), .ctrl(ctrl), .alu_res(alu_res), .ovf(ovf));

  lane_cmp_perm u_cmp (
    .a_op(a_op), .b_op(b_op), .ctrl(ctrl), .cp_res(cp_res), .cmp_flags(cmp_flags)
  );

  writeback_retire u_wb (
    .clk(clk), .rst(rst), .alu_res(alu_res), .cp_res(cp_res), .ovf(ovf),
    .cmp_flags(cmp_flags), .ovf_enable(ovf_enable), .ctrl(ctrl),
    .result(result), .result_valid(result_valid), .flags(flags),
    .ret_code(ret_code), .ret_en(ret_en)
  );

endmodule

//--- simd_unit_props.sv
// simd unit timing properties
module simd_unit_props
  import simd_unit_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input logic      issue_en,
  input logic      result_valid,
  input word_t     result,
  input flags_t    flags,
  input ret_code_t ret_code,
  input logic      ret_en
);
  timeunit 1ns;
  timeprecision 1ps;

  // outputs cleared by reset
  assert property (@(posedge clk) rst |=>
    !result_valid && !ret_en && result == '0 && flags == '0 && ret_code == '0)
    else $error("outputs not cleared after reset");

  assert property (@(posedge clk) disable iff (rst) issue_en |-> ##2 result_valid)
    else $error("result_valid missing two edges after issue");

  assert property (@(posedge clk) disable iff (rst) result_valid |-> $past(issue_en, 2))
    else $error("result_valid without an issue two edges earlier");

  // retire trails the result by one edge
  assert property (@(posedge clk) disable iff (rst) ret_en |-> $past(result_valid))
    else $error("ret_en without a result one edge earlier");

endmodule

bind simd_unit simd_unit_props u_props (
  .clk(clk), .rst(rst), .issue_en(issue_en), .result_valid(result_valid),
  .result(result), .flags(flags), .ret_code(ret_code), .ret_en(ret_en)
);

//--- tb_simd_unit.sv
// simd unit testbench
`include "simd_unit_params.svh"

module tb_simd_unit
  import simd_unit_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PERIOD = 40;
  localparam int RST_CYCLES = 8;
  localparam int N_CYCLES = 600;
  localparam int DRAIN = 4;
  localparam int W = `SIMD_LANE_W;

  typedef struct packed {
    logic [31:0] cyc;
    word_t       res;
    logic        cmp;
    flags_t      fl;
    lane_mask_t  ovf;
  } pend_t;

  logic       clk = 1'b0;
  logic       rst;
  logic       issue_en;
  op_t        op;
  word_t      a_reg;
  word_t      b_reg;
  fwd_sel_t   a_sel;
  fwd_sel_t   b_sel;
  word_t      fwd_bus [`SIMD_NFWD];
  lane_mask_t ovf_enable;
  word_t      result;
  logic       result_valid;
  flags_t     flags;
  ret_code_t  ret_code;
  logic       ret_en;

  integer seed = 32'h5f3c637f;
  int     errors = 0;
  int     cyc = 0;

  // model state
  word_t      hist [`SIMD_NFWD];
  pend_t      pend [$];
  word_t      exp_result;
  logic       exp_valid;
  flags_t     exp_flags;
  lane_mask_t exp_ovf_q;
  logic       exp_ret_en;
  ret_code_t  exp_ret_code;

  op_t op_list [11] = '{OP_ADD, OP_SUB, OP_RSUB, OP_AND, OP_OR, OP_XOR, OP_ANDN,
                        OP_SWAP, OP_DUPLO, OP_CMPEQ, OP_CMPLT};

  always #(PERIOD / 2) clk = ~clk;

  simd_unit DUT (
    .clk(clk), .rst(rst), .issue_en(issue_en), .op(op), .a_reg(a_reg), .b_reg(b_reg),
    .a_sel(a_sel), .b_sel(b_sel), .fwd_bus0(fwd_bus[0]), .fwd_bus1(fwd_bus[1]),
    .fwd_bus2(fwd_bus[2]), .fwd_bus3(fwd_bus[3]), .ovf_enable(ovf_enable),
    .result(result), .result_valid(result_valid), .flags(flags),
    .ret_code(ret_code), .ret_en(ret_en)
  );

  // corner values often, so equality and overflow show up
  function automatic lane_t rand_lane();
    int r;
    r = $random(seed);
    case (r[2:0])
      3'd0: return 32'h0000_0000;
      3'd1: return 32'h7fff_ffff;
      3'd2: return 32'h8000_0000;
      3'd3: return 32'hffff_ffff;
      default: return $random(seed);
    endcase
  endfunction

  function automatic word_t pick_operand(fwd_sel_t sel, word_t reg_val);
    word_t val;
    if (sel == 0 || sel > 8) begin
      val = reg_val;
    end else if (sel <= 4) begin
      val = fwd_bus[sel - 1];
    end else begin
      val = hist[sel - 5];
    end
    return val;
  endfunction

  function automatic pend_t ref_op(op_t o, word_t a, word_t b);
    pend_t       e;
    lane_t       x;
    lane_t       y;
    logic [W:0]  wide;
    e = '0;
    e.cmp = (o == OP_CMPEQ) || (o == OP_CMPLT);
    for (int i = 0; i < `SIMD_LANES; i++) begin
      x = a[W*i +: W];
      y = b[W*i +: W];
      wide = '0;
      case (o)
        OP_ADD:   wide = {x[W-1], x} + {y[W-1], y};
        OP_SUB:   wide = {x[W-1], x} - {y[W-1], y};
        OP_RSUB:  wide = {y[W-1], y} - {x[W-1], x};
        OP_AND:   wide[W-1:0] = x & y;
        OP_OR:    wide[W-1:0] = x | y;
        OP_XOR:   wide[W-1:0] = x ^ y;
        OP_ANDN:  wide[W-1:0] = x & ~y;
        OP_CMPEQ: wide[W-1:0] = {W{x == y}};
        OP_CMPLT: wide[W-1:0] = {W{$signed(x) < $signed(y)}};
        default:  wide = '0;
      endcase
      e.res[W*i +: W] = wide[W-1:0];
      if (o == OP_ADD || o == OP_SUB || o == OP_RSUB) begin
        e.ovf[i] = wide[W] ^ wide[W-1];
      end
      e.fl[2*i] = (x == y);
      e.fl[2*i+1] = $signed(x) < $signed(y);
    end
    if (o == OP_SWAP) begin
      e.res = {a[W-1:0], a[2*W-1:W]};
    end else if (o == OP_DUPLO) begin
      e.res = {a[W-1:0], a[W-1:0]};
    end
    return e;
  endfunction

  // advance the model by one edge, using the inputs the DUT samples there
  task automatic model_step();
    pend_t      e;
    lane_mask_t ovf_next;
    exp_ret_en = |exp_ovf_q;
    exp_ret_code = exp_ret_en ? {`SIMD_RET_OVF, 2'b00, exp_ovf_q} : '0;
    exp_valid = 1'b0;
    ovf_next = '0;
    if (pend.size() > 0 && pend[0].cyc == cyc - 1) begin
      e = pend.pop_front();
      exp_valid = 1'b1;
      exp_result = e.res;
      if (e.cmp) begin
        exp_flags = e.fl;
      end
      ovf_next = e.ovf & ovf_enable;
    end
    exp_ovf_q = ovf_next;
    if (issue_en) begin
      e = ref_op(op, pick_operand(a_sel, a_reg), pick_operand(b_sel, b_reg));
      e.cyc = cyc;
      pend.push_back(e);
    end
    for (int k = 0; k < `SIMD_NFWD; k++) begin
      hist[k] = fwd_bus[k];
    end
    cyc++;
  endtask

  // first quarter issues every cycle, then random gaps
  task automatic drive(input int i);
    int r;
    r = $random(seed);
    issue_en <= (i < N_CYCLES / 4) || (r[1:0] != 2'b00);
    op <= op_list[$unsigned(r) % 11];
    a_sel <= r[11:8];
    b_sel <= r[15:12];
    ovf_enable <= r[17:16];
    a_reg <= {rand_lane(), rand_lane()};
    b_reg <= {rand_lane(), rand_lane()};
    for (int k = 0; k < `SIMD_NFWD; k++) begin
      fwd_bus[k] <= {rand_lane(), rand_lane()};
    end
  endtask

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("Finished with errors");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic check_outputs();
    check(result_valid, exp_valid, "result_valid");
    check(result, exp_result, "result");
    check(flags, exp_flags, "flags");
    check(ret_en, exp_ret_en, "ret_en");
    check(ret_code, exp_ret_code, "ret_code");
  endtask

  initial begin
    rst = 1'b1;
    issue_en = 1'b0;
    op = OP_ADD;
    a_reg = '0;
    b_reg = '0;
    a_sel = '0;
    b_sel = '0;
    ovf_enable = '0;
    for (int k = 0; k < `SIMD_NFWD; k++) begin
      fwd_bus[k] = '0;
      hist[k] = '0;
    end
    exp_result = '0;
    exp_valid = 1'b0;
    exp_flags = '0;
    exp_ovf_q = '0;
    exp_ret_en = 1'b0;
    exp_ret_code = '0;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_outputs();
    for (int i = 0; i < N_CYCLES + DRAIN; i++) begin
      @(posedge clk);
      model_step();
      if (i < N_CYCLES) begin
        drive(i);
      end else begin
        issue_en <= 1'b0;
      end
      @(negedge clk);
      check_outputs();
    end
    if (errors == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("Finished with errors");
      $fatal(1, "mismatches found");
    end
  end

  initial begin
    #((RST_CYCLES + N_CYCLES + DRAIN + 10) * PERIOD);
    $display("timeout: simulation ran past the expected number of cycles");
    $display("Finished with errors");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- sources.f
+incdir+.
simd_unit_pkg.sv
exec_ctrl_if.sv
operand_select.sv
op_decode.sv
lane_alu.sv
lane_cmp_perm.sv
writeback_retire.sv
simd_unit.sv
simd_unit_props.sv
tb_simd_unit.sv
